// File: lsu_pkg.sv
package lsu_pkg;

  // data and address width
  localparam int xlen = 32;

  // one strobe bit per byte
  localparam int strb_w = xlen / 8;

  typedef logic [2:0] ld_func;
  typedef logic [2:0] st_func;

  // load function codes, funct3 style
  localparam ld_func ld_b  = 3'b000;
  localparam ld_func ld_h  = 3'b001;
  localparam ld_func ld_w  = 3'b010;
  localparam ld_func ld_bu = 3'b100;
  localparam ld_func ld_hu = 3'b101;

  // store function codes
  localparam st_func st_b = 3'b000;
  localparam st_func st_h = 3'b001;
  localparam st_func st_w = 3'b010;

endpackage

// File: sram_byte_lane.sv
module sram_byte_lane #(
  parameter int mem_words = 256
) (
  input  logic                         clk,
  input  logic [$clog2(mem_words)-1:0] lane_addr,
  input  logic                         we,
  input  logic [7:0]                   wdata,
  output logic [7:0]                   rdata
);

  logic [7:0] mem [mem_words];

  // read returns the old byte on a same-cycle write
  always_ff @(posedge clk) begin
    if (we) begin
      mem[lane_addr] <= wdata;
    end
    rdata <= mem[lane_addr];
  end

endmodule

// File: axi_sram_slave.sv
module axi_sram_slave
  import lsu_pkg::*;
#(
  parameter int mem_words    = 256,
  parameter int read_latency = 2
) (
  input  logic              clk,
  input  logic              rstn,
  input  logic [xlen-1:0]   araddr,
  input  logic              arvalid,
  output logic              arready,
  output logic [xlen-1:0]   rdata_ram,
  output logic              rvalid,
  input  logic              rready,
  input  logic [xlen-1:0]   awaddr,
  input  logic              awvalid,
  output logic              awready,
  input  logic [xlen-1:0]   wdata_ram,
  input  logic [strb_w-1:0] wstrb,
  input  logic              wvalid,
  output logic              wready,
  output logic              bvalid,
  input  logic              bready
);

  localparam int idx_w = $clog2(mem_words);
  localparam int cnt_w = $clog2(read_latency + 1);

  logic [idx_w-1:0]  lane_addr;
  logic [strb_w-1:0] lane_we;
  logic [xlen-1:0]   lane_wdata;
  logic [xlen-1:0]   lane_rdata;

  logic              ar_fire, r_fire, aw_fire, w_fire, b_fire;
  logic              aw_got, w_got, wr_done, wr_go;
  logic [idx_w-1:0]  aw_idx;
  logic [xlen-1:0]   w_data;
  logic [strb_w-1:0] w_strb;
  logic              rd_busy, rd_cap;
  logic [cnt_w-1:0]  rd_cnt;
  logic [xlen-1:0]   rdata_hold;

  assign ar_fire = arvalid && arready;
  assign r_fire  = rvalid && rready;
  assign aw_fire = awvalid && awready;
  assign w_fire  = wvalid && wready;
  assign b_fire  = bvalid && bready;

  // lane write in the cycle after both channels are in
  assign wr_go = aw_got && w_got && !wr_done;

  // lanes are single ported, so no read issue during a lane write
  assign arready = !rd_busy && !wr_go;
  assign awready = !aw_got;
  assign wready  = !w_got;

  assign lane_addr  = wr_go ? aw_idx : araddr[idx_w+1:2];
  assign lane_we    = {strb_w{wr_go}} & w_strb;
  assign lane_wdata = w_data;

  // lane output is live only in the cycle after issue
  assign rdata_ram = rd_cap ? lane_rdata : rdata_hold;

  for (genvar i = 0; i < strb_w; i++) begin : g_lane
    sram_byte_lane #(
      .mem_words(mem_words)
    ) u_lane (
      .clk      (clk),
      .lane_addr(lane_addr),
      .we       (lane_we[i]),
      .wdata    (lane_wdata[8*i +: 8]),
      .rdata    (lane_rdata[8*i +: 8])
    );
  end

  // write side control
  always_ff @(posedge clk) begin
    if (!rstn) begin
      aw_got  <= 1'b0;
      w_got   <= 1'b0;
      wr_done <= 1'b0;
      bvalid  <= 1'b0;
    end else if (b_fire) begin
      aw_got  <= 1'b0;
      w_got   <= 1'b0;
      wr_done <= 1'b0;
      bvalid  <= 1'b0;
    end else begin
      if (aw_fire) begin
        aw_got <= 1'b1;
      end
      if (w_fire) begin
        w_got <= 1'b1;
      end
      if (wr_go) begin
        wr_done <= 1'b1;
        bvalid  <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (aw_fire) begin
      aw_idx <= awaddr[idx_w+1:2];
    end
    if (w_fire) begin
      w_data <= wdata_ram;
      w_strb <= wstrb;
    end
  end

  // read side, latency counted from the AR handshake
  always_ff @(posedge clk) begin
    if (!rstn) begin
      rd_busy <= 1'b0;
      rd_cnt  <= '0;
      rd_cap  <= 1'b0;
      rvalid  <= 1'b0;
    end else begin
      rd_cap <= ar_fire;
      if (ar_fire) begin
        rd_busy <= 1'b1;
        rd_cnt  <= cnt_w'(1);
        rvalid  <= (read_latency == 1);
      end else if (r_fire) begin
        rd_busy <= 1'b0;
        rvalid  <= 1'b0;
      end else if (rd_busy && !rvalid) begin
        rd_cnt <= rd_cnt + cnt_w'(1);
        if (rd_cnt == cnt_w'(read_latency - 1)) begin
          rvalid <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_cap) begin
      rdata_hold <= lane_rdata;
    end
  end

endmodule

// File: lsu.sv
module lsu
  import lsu_pkg::*;
(
  input  logic              clk,
  input  logic              rstn,

  // load request and response
  input  logic [xlen-1:0]   raddr,
  input  ld_func            rfunc,
  input  logic              rreq_valid,
  output logic              rreq_ready,
  output logic [xlen-1:0]   rdata,
  output logic              rres_valid,
  input  logic              rres_ready,

  // store request and response
  input  logic [xlen-1:0]   waddr,
  input  logic [xlen-1:0]   wdata,
  input  st_func            wfunc,
  input  logic              wreq_valid,
  output logic              wreq_ready,
  output logic              wres_valid,
  input  logic              wres_ready,

  // AXI-lite master
  output logic [xlen-1:0]   araddr,
  output logic              arvalid,
  input  logic              arready,
  input  logic [xlen-1:0]   rdata_ram,
  input  logic              rvalid,
  output logic              rready,
  output logic [xlen-1:0]   awaddr,
  output logic              awvalid,
  input  logic              awready,
  output logic [xlen-1:0]   wdata_ram,
  output logic [strb_w-1:0] wstrb,
  output logic              wvalid,
  input  logic              wready,
  input  logic              bvalid,
  output logic              bready
);

  // read request side
  logic            ar_free, rreq_fire;
  logic            ar_from_req, ar_from_skid, ar_to_skid;
  logic [xlen-1:0] raddr_skid;
  ld_func          rfunc_skid;
  ld_func          ar_func;

  // offset and function of the read waiting on R
  logic [1:0]      r_off;
  ld_func          r_func;

  // read response side
  logic            r_fire, rres_free;
  logic            res_from_r, res_from_hold, r_to_hold;
  logic [xlen-1:0] ld_shift, ld_word, rdata_hold;

  // write side
  logic              aw_free, w_free, wreq_fire;
  logic              aw_from_req, aw_from_park, aw_to_park;
  logic              w_from_req, w_from_park, w_to_park;
  logic              aw_park, w_park;
  logic [xlen-1:0]   awaddr_park, wdata_park;
  logic [strb_w-1:0] wstrb_park;
  logic [strb_w-1:0] st_strb, st_strb_al;
  logic [xlen-1:0]   st_data;

  // store alignment
  always_comb begin
    case (wfunc)
      st_b:    st_strb = 4'b0001;
      st_h:    st_strb = 4'b0011;
      st_w:    st_strb = 4'b1111;
      default: st_strb = 4'b1111;
    endcase
  end

  assign st_data    = wdata << {waddr[1:0], 3'b000};
  assign st_strb_al = st_strb << waddr[1:0];

  // load extraction
  assign ld_shift = rdata_ram >> {r_off, 3'b000};

  always_comb begin
    case (r_func)
      ld_b:    ld_word = {{24{ld_shift[7]}}, ld_shift[7:0]};
      ld_bu:   ld_word = {24'b0, ld_shift[7:0]};
      ld_h:    ld_word = {{16{ld_shift[15]}}, ld_shift[15:0]};
      ld_hu:   ld_word = {16'b0, ld_shift[15:0]};
      ld_w:    ld_word = ld_shift;
      default: ld_word = ld_shift;
    endcase
  end

  // AR issue, from the port or from the skid register
  assign ar_free      = !arvalid || arready;
  assign rreq_fire    = rreq_valid && rreq_ready;
  assign ar_from_req  = rreq_fire && ar_free;
  assign ar_to_skid   = rreq_fire && !ar_free;
  assign ar_from_skid = !rreq_ready && ar_free;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      rreq_ready <= 1'b1;
      arvalid    <= 1'b0;
    end else begin
      if (ar_from_req || ar_from_skid) begin
        arvalid <= 1'b1;
      end else if (arready) begin
        arvalid <= 1'b0;
      end
      if (ar_to_skid) begin
        rreq_ready <= 1'b0;
      end else if (ar_from_skid) begin
        rreq_ready <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ar_from_skid) begin
      araddr  <= raddr_skid;
      ar_func <= rfunc_skid;
    end else if (ar_from_req) begin
      araddr  <= raddr;
      ar_func <= rfunc;
    end
    if (ar_to_skid) begin
      raddr_skid <= raddr;
      rfunc_skid <= rfunc;
    end
    if (arvalid && arready) begin
      r_off  <= araddr[1:0];
      r_func <= ar_func;
    end
  end

  // R data into the response, or parked while rres is stalled
  assign r_fire        = rvalid && rready;
  assign rres_free     = !rres_valid || rres_ready;
  assign res_from_r    = r_fire && rres_free;
  assign r_to_hold     = r_fire && !rres_free;
  assign res_from_hold = !rready && rres_free;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      rres_valid <= 1'b0;
      rready     <= 1'b1;
    end else begin
      if (res_from_r || res_from_hold) begin
        rres_valid <= 1'b1;
      end else if (rres_ready) begin
        rres_valid <= 1'b0;
      end
      if (r_to_hold) begin
        rready <= 1'b0;
      end else if (res_from_hold) begin
        rready <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (res_from_hold) begin
      rdata <= rdata_hold;
    end else if (res_from_r) begin
      rdata <= ld_word;
    end
    if (r_to_hold) begin
      rdata_hold <= ld_word;
    end
  end

  // AW and W issue, each channel parks on its own
  assign aw_free      = !awvalid || awready;
  assign w_free       = !wvalid || wready;
  assign wreq_fire    = wreq_valid && wreq_ready;
  assign aw_from_req  = wreq_fire && aw_free;
  assign aw_to_park   = wreq_fire && !aw_free;
  assign aw_from_park = aw_park && aw_free;
  assign w_from_req   = wreq_fire && w_free;
  assign w_to_park    = wreq_fire && !w_free;
  assign w_from_park  = w_park && w_free;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      wreq_ready <= 1'b1;
      awvalid    <= 1'b0;
      wvalid     <= 1'b0;
      aw_park    <= 1'b0;
      w_park     <= 1'b0;
    end else begin
      if (aw_from_req || aw_from_park) begin
        awvalid <= 1'b1;
      end else if (awready) begin
        awvalid <= 1'b0;
      end
      if (w_from_req || w_from_park) begin
        wvalid <= 1'b1;
      end else if (wready) begin
        wvalid <= 1'b0;
      end
      if (aw_to_park) begin
        aw_park <= 1'b1;
      end else if (aw_from_park) begin
        aw_park <= 1'b0;
      end
      if (w_to_park) begin
        w_park <= 1'b1;
      end else if (w_from_park) begin
        w_park <= 1'b0;
      end
      // ready again once both parked channels have gone out
      if (aw_to_park || w_to_park) begin
        wreq_ready <= 1'b0;
      end else if (!wreq_ready && (!aw_park || aw_free) && (!w_park || w_free)) begin
        wreq_ready <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (aw_from_park) begin
      awaddr <= awaddr_park;
    end else if (aw_from_req) begin
      awaddr <= waddr;
    end
    if (aw_to_park) begin
      awaddr_park <= waddr;
    end
    if (w_from_park) begin
      wdata_ram <= wdata_park;
      wstrb     <= wstrb_park;
    end else if (w_from_req) begin
      wdata_ram <= st_data;
      wstrb     <= st_strb_al;
    end
    if (w_to_park) begin
      wdata_park <= st_data;
      wstrb_park <= st_strb_al;
    end
  end

  // B accepted only when the write response can take it
  assign bready = !wres_valid || wres_ready;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      wres_valid <= 1'b0;
    end else if (bvalid && bready) begin
      wres_valid <= 1'b1;
    end else if (wres_ready) begin
      wres_valid <= 1'b0;
    end
  end

endmodule

// File: lsu_mem_top.sv
module lsu_mem_top
  import lsu_pkg::*;
#(
  parameter int mem_words    = 256,
  parameter int read_latency = 2
) (
  input  logic            clk,
  input  logic            rstn,
  input  logic [xlen-1:0] raddr,
  input  ld_func          rfunc,
  input  logic            rreq_valid,
  output logic            rreq_ready,
  output logic [xlen-1:0] rdata,
  output logic            rres_valid,
  input  logic            rres_ready,
  input  logic [xlen-1:0] waddr,
  input  logic [xlen-1:0] wdata,
  input  st_func          wfunc,
  input  logic            wreq_valid,
  output logic            wreq_ready,
  output logic            wres_valid,
  input  logic            wres_ready
);

  logic [xlen-1:0]   araddr, awaddr;
  logic              arvalid, arready;
  logic [xlen-1:0]   rdata_ram;
  logic              rvalid, rready;
  logic              awvalid, awready;
  logic [xlen-1:0]   wdata_ram;
  logic [strb_w-1:0] wstrb;
  logic              wvalid, wready;
  logic              bvalid, bready;

  lsu u_lsu (
    .clk       (clk),
    .rstn      (rstn),
    .raddr     (raddr),
    .rfunc     (rfunc),
    .rreq_valid(rreq_valid),
    .rreq_ready(rreq_ready),
    .rdata     (rdata),
    .rres_valid(rres_valid),
    .rres_ready(rres_ready),
    .waddr     (waddr),
    .wdata     (wdata),
    .wfunc     (wfunc),
    .wreq_valid(wreq_valid),
    .wreq_ready(wreq_ready),
    .wres_valid(wres_valid),
    .wres_ready(wres_ready),
    .araddr    (araddr),
    .arvalid   (arvalid),
    .arready   (arready),
    .rdata_ram (rdata_ram),
    .rvalid    (rvalid),
    .rready    (rready),
    .awaddr    (awaddr),
    .awvalid   (awvalid),
    .awready   (awready),
    .wdata_ram (wdata_ram),
    .wstrb     (wstrb),
    .wvalid    (wvalid),
    .wready    (wready),
    .bvalid    (bvalid),
    .bready    (bready)
  );

  axi_sram_slave #(
    .mem_words   (mem_words),
    .read_latency(read_latency)
  ) u_sram (
    .clk      (clk),
    .rstn     (rstn),
    .araddr   (araddr),
    .arvalid  (arvalid),
    .arready  (arready),
    .rdata_ram(rdata_ram),
    .rvalid   (rvalid),
    .rready   (rready),
    .awaddr   (awaddr),
    .awvalid  (awvalid),
    .awready  (awready),
    .wdata_ram(wdata_ram),
    .wstrb    (wstrb),
    .wvalid   (wvalid),
    .wready   (wready),
    .bvalid   (bvalid),
    .bready   (bready)
  );

endmodule

// File: tb_lsu_mem.sv
module tb_lsu_mem
  import lsu_pkg::*;
;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int mem_words    = 256;
  localparam int read_latency = 2;
  localparam int idx_w        = $clog2(mem_words);
  localparam logic [31:0] seed = 32'hb4b963fe;

  // lanes start unwritten so all accesses stay in the first words
  localparam int test_words = 64;

  localparam int n_init  = test_words;
  localparam int n_word  = 8;
  localparam int n_sub   = 24;
  localparam int n_ext   = 26;
  localparam int n_burst = 32;
  localparam int n_rand  = 200;
  localparam int max_cycles = 40 * (n_init + n_word + n_sub + n_ext + n_burst + n_rand);

  logic            clk;
  logic            rstn;
  logic [xlen-1:0] raddr;
  ld_func          rfunc;
  logic            rreq_valid;
  logic            rreq_ready;
  logic [xlen-1:0] rdata;
  logic            rres_valid;
  logic            rres_ready;
  logic [xlen-1:0] waddr;
  logic [xlen-1:0] wdata;
  st_func          wfunc;
  logic            wreq_valid;
  logic            wreq_ready;
  logic            wres_valid;
  logic            wres_ready;

  logic [31:0] shadow [mem_words];
  logic [31:0] exp_q [$];
  logic [31:0] stim_state, rdy_state, r, base;
  logic        ready_random, ready_mode;
  ld_func      f;
  int          n_issued, n_resp, n_wres, cycles;

  lsu_mem_top #(
    .mem_words   (mem_words),
    .read_latency(read_latency)
  ) u_lsu_mem_top (
    .clk       (clk),
    .rstn      (rstn),
    .raddr     (raddr),
    .rfunc     (rfunc),
    .rreq_valid(rreq_valid),
    .rreq_ready(rreq_ready),
    .rdata     (rdata),
    .rres_valid(rres_valid),
    .rres_ready(rres_ready),
    .waddr     (waddr),
    .wdata     (wdata),
    .wfunc     (wfunc),
    .wreq_valid(wreq_valid),
    .wreq_ready(wreq_ready),
    .wres_valid(wres_valid),
    .wres_ready(wres_ready)
  );

  always #2 clk = ~clk;

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] next_rand();
    stim_state = lcg_step(stim_state);
    return stim_state;
  endfunction

  // expected load value by shift then extend
  function automatic logic [31:0] expected_load(input logic [31:0] word, input logic [1:0] off,
                                                input ld_func func);
    logic [31:0] sh;
    logic [7:0]  b;
    logic [15:0] h;
    sh = word >> (8 * off);
    b  = sh[7:0];
    h  = sh[15:0];
    case (func)
      ld_b:    return b[7] ? {24'hffffff, b} : {24'h0, b};
      ld_bu:   return {24'h0, b};
      ld_h:    return h[15] ? {16'hffff, h} : {16'h0, h};
      ld_hu:   return {16'h0, h};
      default: return sh;
    endcase
  endfunction

  function automatic void apply_store(input logic [31:0] addr, input logic [31:0] data,
                                      input st_func func);
    int n;
    int off;
    n   = (func == st_b) ? 1 : (func == st_h) ? 2 : 4;
    off = addr[1:0];
    for (int i = 0; i < n; i++) begin
      shadow[addr[idx_w+1:2]][8*(off+i) +: 8] = data[8*i +: 8];
    end
  endfunction

  function automatic ld_func pick_load(input logic [31:0] v);
    case (v % 5)
      0:       return ld_b;
      1:       return ld_bu;
      2:       return ld_h;
      3:       return ld_hu;
      default: return ld_w;
    endcase
  endfunction

  function automatic int load_size(input ld_func func);
    if (func == ld_b || func == ld_bu) begin
      return 1;
    end
    if (func == ld_h || func == ld_hu) begin
      return 2;
    end
    return 4;
  endfunction

  // naturally aligned address inside the written region
  function automatic logic [31:0] rand_addr(input int size);
    logic [31:0] v;
    logic [31:0] idx;
    logic [1:0]  off;
    v   = next_rand();
    idx = (v >> 8) % test_words;
    off = v[1:0];
    if (size == 2) begin
      off[0] = 1'b0;
    end else if (size == 4) begin
      off = 2'b00;
    end
    return {idx[29:0], off};
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error at %0.1f ns: %s = %h, expected %h", $realtime, name, got, exp);
      $display("Checks failed");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  // returns one drive time after the handshake with rreq_valid still high
  task automatic issue_load(input logic [31:0] addr, input ld_func func);
    exp_q.push_back(expected_load(shadow[addr[idx_w+1:2]], addr[1:0], func));
    n_issued++;
    raddr      = addr;
    rfunc      = func;
    rreq_valid = 1'b1;
    while (!rreq_ready) begin
      @(posedge clk);
      #0.5;
    end
    @(posedge clk);
    #0.5;
  endtask

  task automatic drain_loads();
    while (n_resp != n_issued) begin
      @(posedge clk);
      #0.5;
    end
  endtask

  task automatic do_store(input logic [31:0] addr, input logic [31:0] data, input st_func func);
    int target;
    target = n_wres + 1;
    apply_store(addr, data, func);
    waddr      = addr;
    wdata      = data;
    wfunc      = func;
    wreq_valid = 1'b1;
    while (!wreq_ready) begin
      @(posedge clk);
      #0.5;
    end
    @(posedge clk);
    #0.5;
    wreq_valid = 1'b0;
    while (n_wres != target) begin
      @(posedge clk);
      #0.5;
    end
  endtask

  // response ready patterns from a separate generator state
  always @(posedge clk) begin
    ready_mode = ready_random;
    #0.5;
    rdy_state = lcg_step(rdy_state);
    if (ready_mode) begin
      rres_ready = rdy_state[27] | rdy_state[21];
      wres_ready = rdy_state[25];
    end else begin
      rres_ready = 1'b1;
      wres_ready = 1'b1;
    end
  end

  // sampled mid cycle ahead of the handshake edge
  always @(negedge clk) begin
    if (rstn && rres_valid && rres_ready) begin
      if (exp_q.size() == 0) begin
        $display("load response at %0.1f ns with no load outstanding", $realtime);
        $display("Checks failed");
        $fatal(1, "unexpected response");
      end else begin
        check_value("rdata", rdata, exp_q.pop_front());
        n_resp++;
      end
    end
    if (rstn && wres_valid && wres_ready) begin
      n_wres++;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > max_cycles) begin
      $display("timeout after %0d cycles, a transaction never completed", max_cycles);
      $display("Checks failed");
      $fatal(1, "timeout");
    end
  end

  initial begin
    clk          = 1'b0;
    rstn         = 1'b0;
    raddr        = '0;
    rfunc        = ld_w;
    rreq_valid   = 1'b0;
    rres_ready   = 1'b1;
    waddr        = '0;
    wdata        = '0;
    wfunc        = st_w;
    wreq_valid   = 1'b0;
    wres_ready   = 1'b1;
    stim_state   = seed;
    rdy_state    = seed ^ 32'h9e3779b9;
    ready_random = 1'b0;
    n_issued     = 0;
    n_resp       = 0;
    n_wres       = 0;
    cycles       = 0;
    repeat (4) @(posedge clk);
    #0.5;
    rstn = 1'b1;

    check_value("rreq_ready", {31'b0, rreq_ready}, 32'd1);
    check_value("wreq_ready", {31'b0, wreq_ready}, 32'd1);
    check_value("rres_valid", {31'b0, rres_valid}, 32'd0);
    check_value("wres_valid", {31'b0, wres_valid}, 32'd0);

    for (int i = 0; i < test_words; i++) begin
      do_store(i << 2, next_rand(), st_w);
    end

    // word store then word load
    for (int i = 0; i < n_word / 2; i++) begin
      base = rand_addr(4);
      do_store(base, next_rand(), st_w);
      issue_load(base, ld_w);
      rreq_valid = 1'b0;
      drain_loads();
    end

    // sub-word stores at each aligned offset
    for (int w = 0; w < 2; w++) begin
      base = rand_addr(4);
      for (int off = 0; off < 4; off++) begin
        do_store(base | off, next_rand(), st_b);
        issue_load(base, ld_w);
        rreq_valid = 1'b0;
        drain_loads();
      end
      for (int off = 0; off < 4; off += 2) begin
        do_store(base | off, next_rand(), st_h);
        issue_load(base, ld_w);
        rreq_valid = 1'b0;
        drain_loads();
      end
    end

    // sign and zero extension with top bits set and clear
    for (int w = 0; w < 2; w++) begin
      base = rand_addr(4);
      do_store(base, (w == 0) ? 32'h817fc325 : 32'h6ef012a9, st_w);
      for (int off = 0; off < 4; off++) begin
        issue_load(base | off, ld_b);
        issue_load(base | off, ld_bu);
      end
      for (int off = 0; off < 4; off += 2) begin
        issue_load(base | off, ld_h);
        issue_load(base | off, ld_hu);
      end
      rreq_valid = 1'b0;
      drain_loads();
    end

    // back-to-back reads under rres back-pressure
    ready_random = 1'b1;
    for (int i = 0; i < n_burst; i++) begin
      f = pick_load(next_rand() >> 16);
      issue_load(rand_addr(load_size(f)), f);
    end
    rreq_valid = 1'b0;
    drain_loads();

    // random mix where stores wait for outstanding loads
    for (int i = 0; i < n_rand; i++) begin
      r = next_rand();
      if (r[31]) begin
        rreq_valid = 1'b0;
        drain_loads();
        case (r[17:16])
          2'd0:    do_store(rand_addr(1), next_rand(), st_b);
          2'd1:    do_store(rand_addr(2), next_rand(), st_h);
          default: do_store(rand_addr(4), next_rand(), st_w);
        endcase
      end else begin
        f = pick_load(r >> 20);
        issue_load(rand_addr(load_size(f)), f);
        if (r[30]) begin
          rreq_valid = 1'b0;
        end
      end
    end
    rreq_valid = 1'b0;
    drain_loads();

    $display("All checks passed");
    $finish;
  end

endmodule

// File: files.f
lsu_pkg.sv
sram_byte_lane.sv
axi_sram_slave.sv
lsu.sv
lsu_mem_top.sv
tb_lsu_mem.sv
